// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f verilog.f -o tb_dcache &&
./obj_dir/tb_dcache | tee /dev/stderr | grep -q "TB PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: src/dcache.sv
module dcache
    import dcache_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  dmemREN,
    input  logic  dmemWEN,
    input  logic  halt,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    output logic  dhit,
    output logic  flushed,
    output word_t dmemload,
    output logic  dREN,
    output logic  dWEN,
    output word_t daddr,
    output word_t dstore,
    input  logic  dwait,
    input  word_t dload
);

    addr_u            req_addr;
    logic [IDX_W-1:0] frame_idx;
    logic             victim_way;
    logic [WAYS-1:0]  way_we;
    logic             word_sel;
    word_t            wdata;
    logic [TAG_W-1:0] wtag;
    logic             set_valid;
    logic [WAYS-1:0]  valid_we;
    logic             set_dirty;
    logic [WAYS-1:0]  dirty_we;

    // per-way results
    logic [WAYS-1:0]  way_hit;
    logic [WAYS-1:0]  way_valid;
    logic [WAYS-1:0]  way_dirty;
    logic [TAG_W-1:0] way_tag [WAYS];
    word_t            way_data0 [WAYS];
    word_t            way_data1 [WAYS];

    // merged results back to the controller
    logic             hit;
    logic             hit_way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    word_t            victim_data0;
    word_t            victim_data1;

    assign req_addr.raw = dmemaddr;

    dcache_ctrl u_ctrl (
        .CLK, .nRST, .dmemREN, .dmemWEN, .dmemaddr, .dmemstore, .halt,
        .dwait, .dload, .hit, .hit_way, .victim_dirty, .victim_tag,
        .victim_data0, .victim_data1, .dhit, .flushed, .dREN, .dWEN,
        .daddr, .dstore, .frame_idx, .victim_way, .way_we, .word_sel,
        .wdata, .wtag, .set_valid, .valid_we, .set_dirty, .dirty_we
    );

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        dcache_way u_way (
            .CLK, .nRST, .frame_idx, .req_tag(req_addr.f.tag),
            .we(way_we[w]), .word_sel, .wdata, .wtag,
            .set_valid, .valid_we(valid_we[w]), .set_dirty, .dirty_we(dirty_we[w]),
            .hit(way_hit[w]), .valid(way_valid[w]), .dirty(way_dirty[w]),
            .tag(way_tag[w]), .data0(way_data0[w]), .data1(way_data1[w])
        );
    end

    way_select u_sel (
        .way_hit, .way_valid, .way_dirty, .way_tag, .way_data0, .way_data1,
        .blkoff(req_addr.f.blkoff), .victim_way, .hit, .hit_way,
        .load_word(dmemload), .victim_dirty, .victim_tag, .victim_data0, .victim_data1
    );

endmodule

// File: src/dcache_ctrl.sv
module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic             CLK,
    input  logic             nRST,
    input  logic             dmemREN,
    input  logic             dmemWEN,
    input  word_t            dmemaddr,
    input  word_t            dmemstore,
    input  logic             halt,
    input  logic             dwait,
    input  word_t            dload,
    input  logic             hit,
    input  logic             hit_way,
    input  logic             victim_dirty,
    input  logic [TAG_W-1:0] victim_tag,
    input  word_t            victim_data0,
    input  word_t            victim_data1,
    output logic             dhit,
    output logic             flushed,
    output logic             dREN,
    output logic             dWEN,
    output word_t            daddr,
    output word_t            dstore,
    output logic [IDX_W-1:0] frame_idx,
    output logic             victim_way,
    output logic [WAYS-1:0]  way_we,
    output logic             word_sel,
    output word_t            wdata,
    output logic [TAG_W-1:0] wtag,
    output logic             set_valid,
    output logic [WAYS-1:0]  valid_we,
    output logic             set_dirty,
    output logic [WAYS-1:0]  dirty_we
);

    localparam logic [3:0] IDLE    = 4'd0;
    localparam logic [3:0] WB1     = 4'd1;
    localparam logic [3:0] WB2     = 4'd2;
    localparam logic [3:0] FILL1   = 4'd3;
    localparam logic [3:0] FILL2   = 4'd4;
    localparam logic [3:0] FSCAN   = 4'd5;
    localparam logic [3:0] FWB1    = 4'd6;
    localparam logic [3:0] FWB2    = 4'd7;
    localparam logic [3:0] FLUSHED = 4'd8;

    logic [3:0]      state, next_state;
    logic [SETS-1:0] lru;
    logic            lru_we;
    logic            lru_val;
    logic [IDX_W:0]  flush_cnt;
    logic            cnt_inc;
    logic            n_dREN, n_dWEN;
    word_t           n_daddr, n_dstore;
    addr_u           req;
    logic            access;
    logic            done;
    logic            flushing;

    // word address of one half of a block
    function automatic word_t blk_addr(logic [TAG_W-1:0] t, logic [IDX_W-1:0] i, logic off);
        addr_u a;
        a.f.tag    = t;
        a.f.idx    = i;
        a.f.blkoff = off;
        a.f.bytoff = 2'b00;
        return a.raw;
    endfunction

    assign req.raw  = dmemaddr;
    assign access   = dmemREN || dmemWEN;
    assign done     = (dREN || dWEN) && !dwait;
    assign flushing = (state == FSCAN) || (state == FWB1) || (state == FWB2);

    // flush walks way 0 first, then way 1
    assign frame_idx  = flushing ? flush_cnt[IDX_W-1:0] : req.f.idx;
    assign victim_way = flushing ? flush_cnt[IDX_W] : lru[req.f.idx];

    assign dhit    = (state == IDLE) && !halt && access && hit;
    assign flushed = (state == FLUSHED);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            lru       <= '0;
            flush_cnt <= '0;
            dREN      <= 1'b0;
            dWEN      <= 1'b0;
            daddr     <= '0;
            dstore    <= '0;
        end else begin
            state <= next_state;
            if (lru_we) begin
                lru[req.f.idx] <= lru_val;
            end
            if (cnt_inc) begin
                flush_cnt <= flush_cnt + 1'b1;
            end
            dREN   <= n_dREN;
            dWEN   <= n_dWEN;
            daddr  <= n_daddr;
            dstore <= n_dstore;
        end
    end

    always_comb begin
        next_state = state;
        // memory request holds unless a word completes
        n_dREN    = dREN;
        n_dWEN    = dWEN;
        n_daddr   = daddr;
        n_dstore  = dstore;
        way_we    = '0;
        valid_we  = '0;
        dirty_we  = '0;
        word_sel  = req.f.blkoff;
        wdata     = dmemstore;
        wtag      = req.f.tag;
        set_valid = 1'b0;
        set_dirty = 1'b0;
        lru_we    = 1'b0;
        lru_val   = 1'b0;
        cnt_inc   = 1'b0;
        case (state)
            IDLE: begin
                if (halt) begin
                    next_state = FSCAN;
                end else if (dhit) begin
                    lru_we  = 1'b1;
                    lru_val = ~hit_way;
                    if (dmemWEN) begin
                        way_we[hit_way]   = 1'b1;
                        dirty_we[hit_way] = 1'b1;
                        set_dirty         = 1'b1;
                    end
                end else if (access && victim_dirty) begin
                    n_dWEN     = 1'b1;
                    n_daddr    = blk_addr(victim_tag, req.f.idx, 1'b0);
                    n_dstore   = victim_data0;
                    next_state = WB1;
                end else if (access) begin
                    n_dREN     = 1'b1;
                    n_daddr    = blk_addr(req.f.tag, req.f.idx, req.f.blkoff);
                    next_state = FILL1;
                end
            end
            WB1: begin
                if (done) begin
                    n_daddr    = blk_addr(victim_tag, req.f.idx, 1'b1);
                    n_dstore   = victim_data1;
                    next_state = WB2;
                end
            end
            WB2: begin
                if (done) begin
                    n_dWEN     = 1'b0;
                    n_dREN     = 1'b1;
                    n_daddr    = blk_addr(req.f.tag, req.f.idx, req.f.blkoff);
                    next_state = FILL1;
                end
            end
            // requested word comes first
            FILL1: begin
                if (done) begin
                    way_we[victim_way] = 1'b1;
                    wdata              = dload;
                    n_daddr            = blk_addr(req.f.tag, req.f.idx, ~req.f.blkoff);
                    next_state         = FILL2;
                end
            end
            FILL2: begin
                word_sel = ~req.f.blkoff;
                if (done) begin
                    way_we[victim_way]   = 1'b1;
                    wdata                = dload;
                    valid_we[victim_way] = 1'b1;
                    set_valid            = 1'b1;
                    dirty_we[victim_way] = 1'b1;
                    set_dirty            = dmemWEN;
                    lru_we               = 1'b1;
                    lru_val              = ~victim_way;
                    n_dREN               = 1'b0;
                    next_state           = IDLE;
                end
            end
            FSCAN: begin
                if (victim_dirty) begin
                    n_dWEN     = 1'b1;
                    n_daddr    = blk_addr(victim_tag, frame_idx, 1'b0);
                    n_dstore   = victim_data0;
                    next_state = FWB1;
                end else begin
                    // clean or empty frame, just invalidate
                    valid_we[victim_way] = 1'b1;
                    dirty_we[victim_way] = 1'b1;
                    cnt_inc              = 1'b1;
                    if (flush_cnt == '1) begin
                        next_state = FLUSHED;
                    end
                end
            end
            FWB1: begin
                if (done) begin
                    n_daddr    = blk_addr(victim_tag, frame_idx, 1'b1);
                    n_dstore   = victim_data1;
                    next_state = FWB2;
                end
            end
            FWB2: begin
                if (done) begin
                    n_dWEN               = 1'b0;
                    valid_we[victim_way] = 1'b1;
                    dirty_we[victim_way] = 1'b1;
                    cnt_inc              = 1'b1;
                    next_state           = (flush_cnt == '1) ? FLUSHED : FSCAN;
                end
            end
            FLUSHED: begin
                next_state = FLUSHED;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

// File: src/dcache_pkg.sv
package dcache_pkg;

    // data and address words on both buses
    typedef logic [31:0] word_t;

    // cache geometry
    localparam int WAYS      = 2;
    localparam int SETS      = 8;
    localparam int IDX_W     = 3;
    localparam int TAG_W     = 26;
    localparam int BLK_WORDS = 2;

    // one address word, seen either flat or split into its fields
    typedef union packed {
        word_t raw;
        struct packed {
            logic [TAG_W-1:0] tag;
            logic [IDX_W-1:0] idx;
            logic             blkoff;
            logic [1:0]       bytoff;
        } f;
    } addr_u;

endpackage

// File: src/dcache_way.sv
module dcache_way
    import dcache_pkg::*;
(
    input  logic             CLK,
    input  logic             nRST,
    input  logic [IDX_W-1:0] frame_idx,
    input  logic [TAG_W-1:0] req_tag,
    input  logic             we,
    input  logic             word_sel,
    input  word_t            wdata,
    input  logic [TAG_W-1:0] wtag,
    input  logic             set_valid,
    input  logic             valid_we,
    input  logic             set_dirty,
    input  logic             dirty_we,
    output logic             hit,
    output logic             valid,
    output logic             dirty,
    output logic [TAG_W-1:0] tag,
    output word_t            data0,
    output word_t            data1
);

    // frame storage, one entry per set
    logic             valid_q [SETS];
    logic             dirty_q [SETS];
    logic [TAG_W-1:0] tag_q   [SETS];
    word_t            data_q  [SETS][BLK_WORDS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < SETS; i++) begin
                valid_q[i] <= 1'b0;
                dirty_q[i] <= 1'b0;
                tag_q[i]   <= '0;
                for (int j = 0; j < BLK_WORDS; j++) begin
                    data_q[i][j] <= '0;
                end
            end
        end else begin
            // tag is written together with the valid bit
            if (valid_we) begin
                valid_q[frame_idx] <= set_valid;
                tag_q[frame_idx]   <= wtag;
            end
            if (dirty_we) begin
                dirty_q[frame_idx] <= set_dirty;
            end
            if (we) begin
                data_q[frame_idx][word_sel] <= wdata;
            end
        end
    end

    // read side of the indexed frame
    assign valid = valid_q[frame_idx];
    assign dirty = dirty_q[frame_idx];
    assign tag   = tag_q[frame_idx];
    assign data0 = data_q[frame_idx][0];
    assign data1 = data_q[frame_idx][1];

    // tag compare
    assign hit = valid && (tag == req_tag);

endmodule

// File: src/way_select.sv
module way_select
    import dcache_pkg::*;
(
    input  logic [WAYS-1:0]  way_hit,
    input  logic [WAYS-1:0]  way_valid,
    input  logic [WAYS-1:0]  way_dirty,
    input  logic [TAG_W-1:0] way_tag [WAYS],
    input  word_t            way_data0 [WAYS],
    input  word_t            way_data1 [WAYS],
    input  logic             blkoff,
    input  logic             victim_way,
    output logic             hit,
    output logic             hit_way,
    output word_t            load_word,
    output logic             victim_dirty,
    output logic [TAG_W-1:0] victim_tag,
    output word_t            victim_data0,
    output word_t            victim_data1
);

    // at most one way can match a given tag
    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        for (int i = 0; i < WAYS; i++) begin
            if (way_hit[i]) begin
                hit     = 1'b1;
                hit_way = 1'(i);
            end
        end
    end

    // requested word of the hitting way
    assign load_word = blkoff ? way_data1[hit_way] : way_data0[hit_way];

    // frame named by the controller, for write-back
    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];
    assign victim_tag   = way_tag[victim_way];
    assign victim_data0 = way_data0[victim_way];
    assign victim_data1 = way_data1[victim_way];

endmodule

// File: tests/tb_dcache.sv
module tb_dcache
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_REQ        = 200;
    localparam int FLUSH_CYCLES = 200;
    localparam int CLK_NS       = 4;

    logic  CLK, nRST;
    logic  dmemREN, dmemWEN, halt;
    word_t dmemaddr, dmemstore;
    logic  dhit, flushed;
    word_t dmemload;
    logic  dREN, dWEN;
    word_t daddr, dstore;
    logic  dwait;
    word_t dload;

    // memory model and shadow of the expected contents
    word_t mem [word_t];
    word_t shadow [word_t];
    bit    pending_wb [word_t];
    int    wait_left;
    bit    busy;
    bit    half_open;
    word_t last_wb;

    // expected values, refreshed on the falling edge
    word_t exp_load, exp_store;
    bit    blk_pending, pair_ok;

    logic [TAG_W-1:0] tags [3];

    dcache u_dut (.*);

    always #2 CLK = ~CLK;

    function automatic word_t fill_word(word_t a);
        return {~a[31:16], a[15:0]};
    endfunction

    function automatic word_t mem_read(word_t a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    function automatic word_t shadow_read(word_t a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    task automatic stop_run(string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(word_t a);
        assert (mem_read(a) == shadow_read(a))
            else stop_run($sformatf("ERR %0t: memory word %h holds %h, expected %h",
                                    $time, a, mem_read(a), shadow_read(a)));
    endtask

    task automatic do_access(bit wr, word_t addr, word_t data);
        word_t waddr;
        // whole words only, the byte offset selects nothing
        waddr     = addr & ~32'h3;
        dmemREN   = !wr;
        dmemWEN   = wr;
        dmemaddr  = addr;
        dmemstore = data;
        exp_load  = shadow_read(waddr);
        // held until the cache answers
        do begin
            @(posedge CLK);
        end while (!dhit);
        if (wr) begin
            shadow[waddr] = data;
            pending_wb[addr & ~32'h7] = 1'b1;
        end
        @(negedge CLK);
    endtask

    // random wait of zero to three cycles per access
    always @(negedge CLK) begin
        if (nRST && (dREN || dWEN)) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left > 0) begin
                dwait = 1'b1;
                wait_left--;
            end else begin
                dwait = 1'b0;
                busy  = 1'b0;
                dload = mem_read(daddr);
            end
        end else begin
            dwait = 1'b0;
            busy  = 1'b0;
        end
        exp_store   = shadow_read(daddr);
        blk_pending = pending_wb.exists(daddr & ~32'h7);
        pair_ok     = daddr[2] ? (half_open && last_wb == daddr - 32'd4) : !half_open;
    end

    // completed write-backs land in the model
    always @(posedge CLK) begin
        if (nRST && dWEN && !dwait) begin
            mem[daddr] = dstore;
            if (daddr[2]) begin
                half_open = 1'b0;
                pending_wb.delete(daddr & ~32'h7);
            end else begin
                half_open = 1'b1;
                last_wb   = daddr;
            end
        end
    end

    assert property (@(posedge CLK) (!nRST || !$past(nRST)) |-> !dREN && !dWEN && !flushed)
        else stop_run($sformatf("ERR %0t: strobe or flushed high around reset", $time));
    assert property (@(posedge CLK) disable iff (!nRST) (dhit && dmemREN) |-> dmemload == exp_load)
        else stop_run($sformatf("ERR %0t: load from %h, expected %h", $time, dmemaddr, exp_load));
    assert property (@(posedge CLK) disable iff (!nRST)
                     $past(dwait) |-> $stable(dREN) && $stable(dWEN) && $stable(daddr) &&
                     $stable(dstore))
        else stop_run($sformatf("ERR %0t: memory request changed while dwait high", $time));
    assert property (@(posedge CLK) disable iff (!nRST)
                     !(dREN && dWEN) && (!(dREN || dWEN) || daddr[1:0] == 2'b00))
        else stop_run($sformatf("ERR %0t: bad strobes or unaligned daddr %h", $time, daddr));
    assert property (@(posedge CLK) disable iff (!nRST)
                     (dWEN && !dwait) |-> blk_pending && pair_ok && dstore == exp_store)
        else stop_run($sformatf("ERR %0t: write-back of %h to %h, expected %h",
                                $time, dstore, daddr, exp_store));
    assert property (@(posedge CLK) disable iff (!nRST) $past(flushed) |-> flushed)
        else stop_run($sformatf("ERR %0t: flushed dropped after rising", $time));
    assert property (@(posedge CLK) disable iff (!nRST) flushed |-> !dREN && !dWEN)
        else stop_run($sformatf("ERR %0t: memory access after flush", $time));

    initial begin
        #((N_REQ * 60 + FLUSH_CYCLES) * CLK_NS);
        stop_run("timeout: the cache stopped answering before the tests finished");
    end

    initial begin
        word_t addr;
        bit    wr;
        void'($urandom(32'h41e7));
        tags[0]   = 26'h0000000;
        tags[1]   = 26'h0001234;
        tags[2]   = 26'h3fffffc;
        CLK       = 1'b0;
        nRST      = 1'b0;
        dmemREN   = 1'b0;
        dmemWEN   = 1'b0;
        halt      = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        dwait     = 1'b0;
        dload     = '0;
        busy      = 1'b0;
        wait_left = 0;
        half_open = 1'b0;
        last_wb   = '0;
        exp_load  = '0;
        exp_store = '0;
        blk_pending = 1'b0;
        pair_ok   = 1'b1;
        repeat (4) @(negedge CLK);
        nRST = 1'b1;
        // three tags per set force dirty evictions, any byte offset
        for (int n = 0; n < N_REQ; n++) begin
            addr = {tags[$urandom_range(2, 0)], 3'($urandom_range(7, 0)),
                    1'($urandom_range(1, 0)), 2'($urandom_range(3, 0))};
            wr   = $urandom_range(1, 0) == 1;
            do_access(wr, addr, $urandom);
        end
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
        halt    = 1'b1;
        wait (flushed);
        repeat (8) @(negedge CLK);
        foreach (mem[a]) begin
            check_word(a);
        end
        foreach (shadow[a]) begin
            check_word(a);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: verilog.f
src/dcache_pkg.sv
src/dcache_way.sv
src/way_select.sv
src/dcache_ctrl.sv
src/dcache.sv
tests/tb_dcache.sv
